// File: map_245_top.f
source/mapper_pkg.sv
source/mmc3_regs.sv
source/prg_bank_map.sv
source/chr_bank_map.sv
source/scanline_irq.sv
source/map_245_top.sv
testbench/map_245_assertions.sv
testbench/map_245_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f map_245_top.f --top-module map_245_tb -o map_245_sim
./obj_dir/map_245_sim | tee sim.log
grep -q "All tests passed" sim.log

// File: source/chr_bank_map.sv
`timescale 1ns/10ps

module chr_bank_map import mapper_pkg::*; (
	input  logic [13:0]           ppu_addr,
	input  logic                  ppu_we,
	input  logic                  cfg_chr_ram,
	input  logic                  mir_horiz,
	input  logic [chr_bank_w-1:0] r0,
	input  logic [chr_bank_w-1:0] r1,
	input  logic [chr_bank_w-1:0] r2,
	input  logic [chr_bank_w-1:0] r3,
	input  logic [chr_bank_w-1:0] r4,
	input  logic [chr_bank_w-1:0] r5,
	input  logic                  chr_inv,
	output logic                  chr_a11_sel,
	output logic                  ciram_a10,
	output logic                  ciram_ce,
	output logic                  chr_ce,
	output logic                  chr_we
);

	// a12 seen by the bank logic
	logic a12_int;
	// 1k bank number the mmc3 would drive
	logic [chr_bank_w-1:0] sel_bank;

	// ppu a12 is tied low on this board, so only the inversion bit is left
	assign a12_int = chr_inv;

	always_comb begin
		if (!a12_int) begin
			// 2k banks, a10 would replace bit 0
			// bit 1 still comes from the register
			if (ppu_addr[11]) begin
				sel_bank = r1;
			end else begin
				sel_bank = r0;
			end
		end else begin
			// 1k banks
			case (ppu_addr[11:10])
				2'b00: sel_bank = r2;
				2'b01: sel_bank = r3;
				2'b10: sel_bank = r4;
				default: sel_bank = r5;
			endcase
		end
	end

	// chr a11 of the selected bank, becomes prg a19
	assign chr_a11_sel = sel_bank[1];

	// nametables live above 0x2000
	assign ciram_ce = ppu_addr[13];
	assign chr_ce = ~ppu_addr[13];

	// vertical uses a10, horizontal uses a11
	assign ciram_a10 = mir_horiz ? ppu_addr[11] : ppu_addr[10];

	// ppu write strobe is active low
	// only ram carts accept pattern writes
	assign chr_we = cfg_chr_ram & ~ppu_we & ~ppu_addr[13];

endmodule

// File: source/map_245_top.sv
`timescale 1ns/10ps

module map_245_top import mapper_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_data_in,
	input  logic        cpu_rw,
	input  logic        cpu_m2,
	input  logic [13:0] ppu_addr,
	input  logic        ppu_oe,
	input  logic        ppu_we,
	input  logic        cfg_chr_ram,
	input  logic [7:0]  prg_do,
	input  logic [7:0]  srm_do,
	input  logic [7:0]  chr_do,
	output logic        prg_ce,
	output logic        prg_oe,
	output logic [19:0] prg_addr,
	output logic        srm_ce,
	output logic        srm_oe,
	output logic        srm_we,
	output logic [12:0] srm_addr,
	output logic        chr_ce,
	output logic        chr_oe,
	output logic        chr_we,
	output logic [12:0] chr_addr,
	output logic        ciram_a10,
	output logic        ciram_ce,
	output logic        irq,
	output logic        map_cpu_oe,
	output logic [7:0]  map_cpu_do,
	output logic        map_ppu_oe,
	output logic [7:0]  map_ppu_do
);

	logic [chr_bank_w-1:0] r0, r1, r2, r3, r4, r5;
	logic [prg_bank_w-1:0] r6, r7;
	logic chr_inv;
	logic prg_mode;
	logic mir_horiz;
	logic [7:0] irq_latch;
	logic irq_reload;
	logic irq_disable;
	logic irq_enable;
	// outer prg half from the chr side
	logic chr_a11_sel;
	logic [6:0] prg_addr_hi;

	mmc3_regs regs_inst (
		.clk(clk), .reset(reset),
		.cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in),
		.cpu_rw(cpu_rw), .cpu_m2(cpu_m2),
		.r0(r0), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .r5(r5),
		.r6(r6), .r7(r7),
		.chr_inv(chr_inv), .prg_mode(prg_mode), .mir_horiz(mir_horiz),
		.irq_latch(irq_latch), .irq_reload(irq_reload),
		.irq_disable(irq_disable), .irq_enable(irq_enable)
	);

	prg_bank_map prg_inst (
		.cpu_a14(cpu_addr[14]), .cpu_a13(cpu_addr[13]),
		.r6(r6), .r7(r7), .prg_mode(prg_mode),
		.chr_a11_sel(chr_a11_sel), .prg_addr_hi(prg_addr_hi)
	);

	chr_bank_map chr_inst (
		.ppu_addr(ppu_addr), .ppu_we(ppu_we), .cfg_chr_ram(cfg_chr_ram),
		.mir_horiz(mir_horiz),
		.r0(r0), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .r5(r5),
		.chr_inv(chr_inv), .chr_a11_sel(chr_a11_sel),
		.ciram_a10(ciram_a10), .ciram_ce(ciram_ce),
		.chr_ce(chr_ce), .chr_we(chr_we)
	);

	scanline_irq irq_inst (
		.clk(clk), .reset(reset), .ppu_a12(ppu_addr[12]),
		.irq_latch(irq_latch), .irq_reload(irq_reload),
		.irq_disable(irq_disable), .irq_enable(irq_enable), .irq(irq)
	);

	// work ram at 0x6000..0x7fff
	assign srm_ce = (cpu_addr[15:13] == 3'b011);
	assign srm_oe = cpu_rw;
	assign srm_we = ~cpu_rw;
	assign srm_addr = cpu_addr[12:0];

	// rom in the upper half, never written
	assign prg_ce = cpu_addr[15];
	assign prg_oe = cpu_rw;
	assign prg_addr = {prg_addr_hi, cpu_addr[12:0]};

	// 8k pattern memory straight from the ppu
	assign chr_addr = ppu_addr[12:0];
	// ppu read strobe is active low
	assign chr_oe = ~ppu_oe;

	// cpu read data, work ram has priority
	assign map_cpu_oe = (srm_ce | prg_ce) & cpu_rw;
	assign map_cpu_do = srm_ce ? srm_do : prg_do;

	// ppu read data, nothing internal to return
	assign map_ppu_oe = chr_ce & chr_oe;
	assign map_ppu_do = chr_do;

endmodule

// File: source/mapper_pkg.sv
package mapper_pkg;

	// 8 KiB prg bank number, 512 KiB per outer half
	localparam int prg_bank_w = 6;

	// 1 KiB chr bank number as written by the cpu
	localparam int chr_bank_w = 8;

	// clk cycles a12 must sit low before a rise is taken
	// shorter dips come from sprite fetches and are ignored
	localparam int a12_low_min = 4;

	// fixed windows at the top of the prg space
	localparam logic [prg_bank_w-1:0] prg_fixed_last = '1;
	localparam logic [prg_bank_w-1:0] prg_fixed_second_last = prg_fixed_last - 1'b1;

	// cpu data byte of a register write
	// 0x8000 reads it as fields, every other register as a plain byte
	typedef union packed {
		struct packed {
			// bit 7, swap 2k and 1k chr halves
			logic chr_inv;
			// bit 6, swap prg windows 0 and 2
			logic prg_mode;
			// bits 5..3, no function on this board
			logic [2:0] unused;
			// bits 2..0, target of the next 0x8001 write
			logic [2:0] reg_idx;
		} sel;
		logic [7:0] raw;
	} mmc3_wdata_u;

endpackage

// File: source/mmc3_regs.sv
`timescale 1ns/10ps

module mmc3_regs import mapper_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [15:0]           cpu_addr,
	input  logic [7:0]            cpu_data_in,
	input  logic                  cpu_rw,
	input  logic                  cpu_m2,
	output logic [chr_bank_w-1:0] r0,
	output logic [chr_bank_w-1:0] r1,
	output logic [chr_bank_w-1:0] r2,
	output logic [chr_bank_w-1:0] r3,
	output logic [chr_bank_w-1:0] r4,
	output logic [chr_bank_w-1:0] r5,
	output logic [prg_bank_w-1:0] r6,
	output logic [prg_bank_w-1:0] r7,
	output logic                  chr_inv,
	output logic                  prg_mode,
	output logic                  mir_horiz,
	output logic [7:0]            irq_latch,
	output logic                  irq_reload,
	output logic                  irq_disable,
	output logic                  irq_enable
);

	// m2 as seen on the previous clk edge
	logic m2_prev;
	// one clk per bus cycle, at the m2 rise
	logic wr_stb;
	// {a14, a13, a0} picks one of eight registers
	logic [2:0] reg_addr;
	// index latched by the last 0x8000 write
	logic [2:0] bank_sel;
	mmc3_wdata_u wdata;

	assign wdata.raw = cpu_data_in;
	assign reg_addr = {cpu_addr[14:13], cpu_addr[0]};

	// rising m2 with a write to the upper half of the cpu space
	assign wr_stb = cpu_m2 & ~m2_prev & ~cpu_rw & cpu_addr[15];

	always_ff @(posedge clk) begin
		if (reset) begin
			m2_prev <= 1'b0;
		end else begin
			m2_prev <= cpu_m2;
		end
	end

	// register file
	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
			r1 <= '0;
			r2 <= '0;
			r3 <= '0;
			r4 <= '0;
			r5 <= '0;
			r6 <= '0;
			r7 <= '0;
			bank_sel <= 3'd0;
			chr_inv <= 1'b0;
			prg_mode <= 1'b0;
			// vertical mirroring out of reset
			mir_horiz <= 1'b0;
			irq_latch <= 8'd0;
		end else if (wr_stb) begin
			case (reg_addr)
				// 0x8000 bank select
				3'b000: begin
					bank_sel <= wdata.sel.reg_idx;
					chr_inv <= wdata.sel.chr_inv;
					prg_mode <= wdata.sel.prg_mode;
				end
				// 0x8001 bank data into the selected slot
				3'b001: begin
					case (bank_sel)
						3'd0: r0 <= wdata.raw[chr_bank_w-1:0];
						3'd1: r1 <= wdata.raw[chr_bank_w-1:0];
						3'd2: r2 <= wdata.raw[chr_bank_w-1:0];
						3'd3: r3 <= wdata.raw[chr_bank_w-1:0];
						3'd4: r4 <= wdata.raw[chr_bank_w-1:0];
						3'd5: r5 <= wdata.raw[chr_bank_w-1:0];
						// prg banks keep only the low bits
						3'd6: r6 <= wdata.raw[prg_bank_w-1:0];
						default: r7 <= wdata.raw[prg_bank_w-1:0];
					endcase
				end
				// 0xa000 mirroring, bit 0 set means horizontal
				3'b010: mir_horiz <= wdata.raw[0];
				// 0xc000 scanline reload value
				3'b100: irq_latch <= wdata.raw;
				// 0xa001 ram protect and the irq strobes hold no data here
				default: begin
				end
			endcase
		end
	end

	// irq control strobes, one clk wide after the write edge
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_reload <= 1'b0;
			irq_disable <= 1'b0;
			irq_enable <= 1'b0;
		end else begin
			// 0xc001
			irq_reload <= wr_stb & (reg_addr == 3'b101);
			// 0xe000
			irq_disable <= wr_stb & (reg_addr == 3'b110);
			// 0xe001
			irq_enable <= wr_stb & (reg_addr == 3'b111);
		end
	end

endmodule

// File: source/prg_bank_map.sv
`timescale 1ns/10ps

module prg_bank_map import mapper_pkg::*; (
	input  logic                  cpu_a14,
	input  logic                  cpu_a13,
	input  logic [prg_bank_w-1:0] r6,
	input  logic [prg_bank_w-1:0] r7,
	input  logic                  prg_mode,
	input  logic                  chr_a11_sel,
	output logic [6:0]            prg_addr_hi
);

	// bank for the 8k window being accessed
	logic [prg_bank_w-1:0] bank;

	// windows at 0x8000, 0xa000, 0xc000, 0xe000
	always_comb begin
		case ({cpu_a14, cpu_a13})
			// mode 1 moves the fixed bank down here
			2'b00: begin
				if (prg_mode) begin
					bank = prg_fixed_second_last;
				end else begin
					bank = r6;
				end
			end
			// always switchable
			2'b01: bank = r7;
			// r6 lands here in mode 1
			2'b10: begin
				if (prg_mode) begin
					bank = r6;
				end else begin
					bank = prg_fixed_second_last;
				end
			end
			// last bank, holds the vectors
			default: bank = prg_fixed_last;
		endcase
	end

	// 245 takes the outer 512k half from the chr bank
	// fixed banks follow it too, so both halves carry vectors
	assign prg_addr_hi = {chr_a11_sel, bank};

endmodule

// File: source/scanline_irq.sv
`timescale 1ns/10ps

module scanline_irq import mapper_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       ppu_a12,
	input  logic [7:0] irq_latch,
	input  logic       irq_reload,
	input  logic       irq_disable,
	input  logic       irq_enable,
	output logic       irq
);

	localparam int low_cnt_w = $clog2(a12_low_min + 1);

	// cycles a12 has been low, stops at the minimum
	logic [low_cnt_w-1:0] low_cnt;
	// filtered rising edge of a12
	logic a12_rise;
	logic [7:0] cnt;
	logic [7:0] cnt_next;
	// reload requested by 0xc001, taken on the next rise
	logic reload_pend;
	logic irq_en;
	// counter hit zero with irq enabled, flag follows one clk later
	logic irq_hit;

	assign a12_rise = ppu_a12 & (low_cnt == low_cnt_w'(a12_low_min));

	// empty or pending counter reloads, otherwise count down
	assign cnt_next = ((cnt == 8'd0) || reload_pend) ? irq_latch : cnt - 8'd1;

	// a12 low-time filter
	always_ff @(posedge clk) begin
		if (reset) begin
			low_cnt <= '0;
		end else if (ppu_a12) begin
			low_cnt <= '0;
		end else if (low_cnt != low_cnt_w'(a12_low_min)) begin
			low_cnt <= low_cnt + 1'b1;
		end
	end

	// scanline counter
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= 8'd0;
			reload_pend <= 1'b0;
		end else if (a12_rise) begin
			cnt <= cnt_next;
			reload_pend <= 1'b0;
		end else if (irq_reload) begin
			reload_pend <= 1'b1;
		end
	end

	// enable bit and irq flag, disable wins over everything
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_en <= 1'b0;
			irq_hit <= 1'b0;
			irq <= 1'b0;
		end else if (irq_disable) begin
			irq_en <= 1'b0;
			irq_hit <= 1'b0;
			irq <= 1'b0;
		end else begin
			if (irq_enable) begin
				irq_en <= 1'b1;
			end
			irq_hit <= a12_rise & (cnt_next == 8'd0) & irq_en;
			// flag stays up until 0xe000
			if (irq_hit) begin
				irq <= 1'b1;
			end
		end
	end

endmodule

// File: testbench/map_245_assertions.sv
`timescale 1ns/10ps

module map_245_assertions (
	input logic clk,
	input logic reset,
	input logic chr_we,
	input logic ciram_ce,
	input logic srm_ce,
	input logic prg_ce,
	input logic irq
);

	// failed assertions so far, read back by the testbench
	int assert_fails = 0;

	// pattern writes never reach the nametables
	chr_we_vs_ciram: assert property (@(posedge clk) disable iff (reset) !(chr_we && ciram_ce))
		else begin
			$error("chr_we high during a nametable access");
			assert_fails++;
		end

	// work ram and rom decode are disjoint
	srm_vs_prg: assert property (@(posedge clk) disable iff (reset) !(srm_ce && prg_ce))
		else begin
			$error("srm_ce and prg_ce high together");
			assert_fails++;
		end

	// flag comes out of reset low
	irq_after_reset: assert property (@(posedge clk) $past(reset) |-> !irq)
		else begin
			$error("irq high in the cycle after reset");
			assert_fails++;
		end

endmodule

bind map_245_top map_245_assertions assertions_inst (
	.clk(clk), .reset(reset), .chr_we(chr_we), .ciram_ce(ciram_ce),
	.srm_ce(srm_ce), .prg_ce(prg_ce), .irq(irq)
);

// File: testbench/map_245_tb.sv
`timescale 1ns/10ps

module map_245_tb import mapper_pkg::*; ();

	logic clk;
	logic reset;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_data_in;
	logic cpu_rw;
	logic cpu_m2;
	logic [13:0] ppu_addr;
	logic ppu_oe;
	logic ppu_we;
	logic cfg_chr_ram;
	logic [7:0] prg_do, srm_do, chr_do;
	logic prg_ce, prg_oe, srm_ce, srm_oe, srm_we, chr_ce, chr_oe, chr_we;
	logic ciram_a10, ciram_ce, irq, map_cpu_oe, map_ppu_oe;
	logic [19:0] prg_addr;
	logic [12:0] srm_addr, chr_addr;
	logic [7:0] map_cpu_do, map_ppu_do;

	// reference copy of the mapper state
	logic [7:0] m_bank [0:7];
	logic [2:0] m_sel;
	logic m_inv, m_mode, m_horiz, m_pend, m_en, m_irq;
	logic [7:0] m_latch, m_cnt;
	integer seed;
	integer error_count;
	integer check_count;
	logic [31:0] rnd;

	map_245_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		check_count++;
		if (exp_v !== act_v) begin
			error_count++;
			$display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
		end
	endtask

	// one bus cycle with m2 low two clocks then high two clocks
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		mmc3_wdata_u w;
		w.raw = data;
		cpu_addr = addr;
		cpu_data_in = data;
		cpu_rw = 1'b0;
		cpu_m2 = 1'b0;
		repeat (2) @(negedge clk);
		cpu_m2 = 1'b1;
		repeat (2) @(negedge clk);
		cpu_m2 = 1'b0;
		cpu_rw = 1'b1;
		// register picked by a14, a13 and a0
		case ({addr[14:13], addr[0]})
			3'b000: begin
				m_sel = w.sel.reg_idx;
				m_inv = w.sel.chr_inv;
				m_mode = w.sel.prg_mode;
			end
			3'b001: begin
				if (m_sel >= 3'd6) begin
					m_bank[m_sel] = 8'(data[prg_bank_w-1:0]);
				end else begin
					m_bank[m_sel] = data;
				end
			end
			3'b010: m_horiz = data[0];
			3'b100: m_latch = data;
			3'b101: m_pend = 1'b1;
			3'b110: begin
				m_en = 1'b0;
				m_irq = 1'b0;
			end
			3'b111: m_en = 1'b1;
			default: begin
			end
		endcase
	endtask

	task automatic bank_select(input logic [2:0] idx, input logic inv, input logic mode);
		mmc3_wdata_u w;
		w.sel.chr_inv = inv;
		w.sel.prg_mode = mode;
		// junk in the unused field
		w.sel.unused = ~idx;
		w.sel.reg_idx = idx;
		cpu_write(16'h8000, w.raw);
	endtask

	// a12 is forced low, so the inversion bit alone picks 2k or 1k banks
	function automatic logic [7:0] exp_chr_bank(input logic [13:0] pa);
		if (!m_inv) begin
			exp_chr_bank = pa[11] ? m_bank[1] : m_bank[0];
		end else begin
			exp_chr_bank = m_bank[{1'b0, pa[11:10]} + 3'd2];
		end
	endfunction

	function automatic logic [prg_bank_w-1:0] exp_prg_bank(input logic [15:0] a);
		case (a[14:13])
			2'b00: exp_prg_bank = m_mode ? prg_fixed_second_last : m_bank[6][prg_bank_w-1:0];
			2'b01: exp_prg_bank = m_bank[7][prg_bank_w-1:0];
			2'b10: exp_prg_bank = m_mode ? m_bank[6][prg_bank_w-1:0] : prg_fixed_second_last;
			default: exp_prg_bank = prg_fixed_last;
		endcase
	endfunction

	// a12 low for low_len clocks then high for high_len
	// the model counts only long lows
	task automatic a12_pulse(input int low_len, input int high_len);
		ppu_addr[12] = 1'b0;
		repeat (low_len) @(negedge clk);
		ppu_addr[12] = 1'b1;
		repeat (high_len) @(negedge clk);
		if (low_len >= a12_low_min) begin
			if (m_cnt == 8'd0 || m_pend) begin
				m_cnt = m_latch;
			end else begin
				m_cnt = m_cnt - 8'd1;
			end
			m_pend = 1'b0;
			if (m_cnt == 8'd0 && m_en) begin
				m_irq = 1'b1;
			end
		end
	endtask

	task automatic settle_irq();
		int n;
		n = 0;
		if (m_irq) begin
			// flag lands two clocks after the counting edge
			while (irq !== 1'b1 && n < 8) begin
				@(negedge clk);
				n++;
			end
			if (irq !== 1'b1) begin
				error_count++;
				$display("irq did not rise within 8 cycles of the counting a12 edge");
			end
		end else begin
			repeat (3) @(negedge clk);
			compare_value("irq_early", 32'h0, 32'(irq));
		end
	endtask

	task automatic check_prg_map();
		logic [7:0] cb;
		logic [prg_bank_w-1:0] pb;
		for (int t = 0; t < 24; t++) begin
			for (int k = 0; k < 8; k++) begin
				rnd = rand32();
				bank_select(3'(k), rnd[8], rnd[9]);
				cpu_write(16'h8001, rnd[7:0]);
			end
			rnd = rand32();
			bank_select(rnd[2:0], rnd[3], rnd[4]);
			repeat (8) begin
				rnd = rand32();
				cpu_addr = {1'b1, rnd[14:0]};
				ppu_addr = rnd[29:16];
				#2;
				cb = exp_chr_bank(ppu_addr);
				pb = exp_prg_bank(cpu_addr);
				compare_value("prg_map", 32'({pb, cpu_addr[12:0]}), 32'(prg_addr[18:0]));
				// outer 512k half from chr bank bit 1
				compare_value("outer_bank", 32'(cb[1]), 32'(prg_addr[19]));
				@(negedge clk);
			end
		end
	endtask

	task automatic check_chr_ppu();
		for (int t = 0; t < 40; t++) begin
			rnd = rand32();
			if (t % 8 == 0) begin
				cpu_write(16'hA000, rnd[7:0]);
			end
			rnd = rand32();
			ppu_addr = rnd[13:0];
			ppu_we = rnd[14];
			cfg_chr_ram = rnd[15];
			#2;
			compare_value("ciram_ce", 32'(ppu_addr[13]), 32'(ciram_ce));
			compare_value("ciram_a10", 32'(m_horiz ? ppu_addr[11] : ppu_addr[10]),
				32'(ciram_a10));
			compare_value("chr_addr", 32'(ppu_addr[12:0]), 32'(chr_addr));
			// ppu strobes are active low
			compare_value("chr_we", 32'(cfg_chr_ram && !ppu_addr[13] && !ppu_we),
				32'(chr_we));
			@(negedge clk);
		end
	endtask

	task automatic check_read_mux();
		logic sel_srm;
		for (int t = 0; t < 40; t++) begin
			rnd = rand32();
			// m2 stays low, so rw low here never writes
			cpu_addr = rnd[15:0];
			cpu_rw = rnd[16];
			ppu_addr = rnd[29:16];
			ppu_oe = rnd[30];
			rnd = rand32();
			prg_do = rnd[7:0];
			srm_do = rnd[15:8];
			chr_do = rnd[23:16];
			#2;
			sel_srm = (cpu_addr[15:13] == 3'b011);
			compare_value("srm_ce", 32'(sel_srm), 32'(srm_ce));
			compare_value("srm_oe", 32'(cpu_rw), 32'(srm_oe));
			compare_value("srm_we", 32'(!cpu_rw), 32'(srm_we));
			compare_value("srm_addr", 32'(cpu_addr[12:0]), 32'(srm_addr));
			compare_value("prg_ce", 32'(cpu_addr[15]), 32'(prg_ce));
			compare_value("prg_oe", 32'(cpu_rw), 32'(prg_oe));
			compare_value("cpu_oe", 32'((sel_srm | cpu_addr[15]) & cpu_rw), 32'(map_cpu_oe));
			if (cpu_rw && (sel_srm || cpu_addr[15])) begin
				compare_value("cpu_do", 32'(sel_srm ? srm_do : prg_do), 32'(map_cpu_do));
			end
			// pattern memory below 0x2000, read strobe active low
			compare_value("chr_ce", 32'(!ppu_addr[13]), 32'(chr_ce));
			compare_value("chr_oe", 32'(!ppu_oe), 32'(chr_oe));
			compare_value("ppu_oe", 32'(!ppu_addr[13] && !ppu_oe), 32'(map_ppu_oe));
			compare_value("ppu_do", 32'(chr_do), 32'(map_ppu_do));
			@(negedge clk);
		end
		cpu_rw = 1'b1;
	endtask

	task automatic check_scanline_irq();
		logic [7:0] lat;
		rnd = rand32();
		lat = 8'd1 + {5'd0, rnd[2:0]};
		// a12 parked high during setup
		ppu_addr = 14'h1000;
		cpu_write(16'hC000, lat);
		cpu_write(16'hC001, rnd[15:8]);
		cpu_write(16'hE001, rnd[23:16]);
		for (int p = 0; p <= int'(lat); p++) begin
			rnd = rand32();
			// sprite fetch dip too short to count
			a12_pulse(1 + int'(rnd[0]) + int'(rnd[1]), 1);
			a12_pulse(a12_low_min + int'(rnd[4:2]), 2);
			settle_irq();
		end
		cpu_write(16'hE000, 8'd0);
		compare_value("irq_clear", 32'(m_irq), 32'(irq));
		// counter wraps back to zero with irq disabled
		for (int p = 0; p <= int'(lat); p++) begin
			a12_pulse(a12_low_min + 2, 2);
			settle_irq();
		end
		ppu_addr = 14'h0000;
	endtask

	initial begin
		seed = 32'h4a0;
		error_count = 0;
		check_count = 0;
		reset = 1'b1;
		cpu_addr = 16'h0000;
		cpu_data_in = 8'h00;
		cpu_rw = 1'b1;
		cpu_m2 = 1'b0;
		ppu_addr = 14'h0000;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		cfg_chr_ram = 1'b0;
		prg_do = 8'h00;
		srm_do = 8'h00;
		chr_do = 8'h00;
		for (int i = 0; i < 8; i++) begin
			m_bank[i] = 8'd0;
		end
		m_sel = 3'd0;
		{m_inv, m_mode, m_horiz, m_pend, m_en, m_irq} = 6'b0;
		m_latch = 8'd0;
		m_cnt = 8'd0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		compare_value("irq_reset", 32'h0, 32'(irq));
		check_prg_map();
		check_chr_ppu();
		check_read_mux();
		check_scanline_irq();
		$display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
			DUT.assertions_inst.assert_fails);
		if (error_count == 0 && DUT.assertions_inst.assert_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
